// File: dv/noise_model.svh
`ifndef NOISE_MODEL_SVH
`define NOISE_MODEL_SVH

// cycle model of the noise voice, stepped on each rising edge
int unsigned m_frame;  // cycles into the current 256 Hz step
int unsigned m_ticks;  // length ticks since reset
noise_regs_t m_regs;
logic        m_trig;
logic        m_len_wr;
int unsigned m_len;
logic        m_active;
int unsigned m_vol;
int unsigned m_per;
logic [14:0] m_lfsr;
int unsigned m_div;
logic [3:0]  m_sample;
int unsigned err_cnt;
int unsigned chk_cnt;

task automatic model_step(input logic rst, input apu_bus_req_t req);
	logic        len_tick;
	logic        env_tick;
	logic        fb;
	int unsigned period;
	if (rst) begin
		m_frame  = 0;
		m_ticks  = 0;
		m_regs   = '0;
		m_trig   = 1'b0;
		m_len_wr = 1'b0;
		m_len    = 0;
		m_active = 1'b0;
		m_vol    = 0;
		m_per    = 0;
		m_lfsr   = '0;
		m_div    = 0;
		m_sample = 4'h0;
		return;
	end
	len_tick = (m_frame == FRAME_DIV - 1);
	env_tick = len_tick && (m_ticks % 4 == 3); // every fourth step
	// output register sees the state before this edge
	m_sample = (m_active && !m_lfsr[0]) ? 4'(m_vol) : 4'h0;
	period = (m_regs.poly.div_code == 3'd0) ? 8 : 16 * int'(m_regs.poly.div_code);
	period = period << m_regs.poly.shift;
	if (m_trig) begin
		m_lfsr = 15'h7fff;
		m_div  = 0;
	end else if (m_active) begin
		if (m_div + 1 >= period) begin
			fb     = m_lfsr[0] ^ m_lfsr[1];
			m_lfsr = {fb, m_lfsr[14:1]};
			if (m_regs.poly.width7)
				m_lfsr[6] = fb; // short mode
			m_div = 0;
		end else begin
			m_div++;
		end
	end
	if (m_trig) begin
		if (m_len == 0)
			m_len = 64;
		m_active = (m_regs.env.init_vol != 4'h0) || m_regs.env.env_up;
	end else if (m_len_wr) begin
		m_len = 64 - m_regs.len_load;
	end else if (len_tick && m_regs.len_en && m_len != 0) begin
		m_len--;
		if (m_len == 0)
			m_active = 1'b0; // expiry
	end
	if (m_trig) begin
		m_vol = m_regs.env.init_vol;
		m_per = m_regs.env.env_period;
	end else if (env_tick && m_regs.env.env_period != 3'd0) begin
		if (m_per > 1) begin
			m_per--;
		end else begin
			m_per = m_regs.env.env_period;
			if (m_regs.env.env_up && m_vol < 15)
				m_vol++;
			else if (!m_regs.env.env_up && m_vol > 0)
				m_vol--;
		end
	end
	m_trig   = req.wr && (req.addr == REG_CTRL) && req.wdata[7];
	m_len_wr = req.wr && (req.addr == REG_LEN);
	if (req.wr) begin
		case (req.addr)
			REG_LEN:  m_regs.len_load = req.wdata[5:0];
			REG_ENV:  m_regs.env = env_cfg_t'(req.wdata);
			REG_POLY: m_regs.poly = poly_cfg_t'(req.wdata);
			default:  m_regs.len_en = req.wdata[6];
		endcase
	end
	if (len_tick) begin
		m_frame = 0;
		m_ticks++;
	end else begin
		m_frame++;
	end
endtask

// read-back rule, unreadable bits as ones
function automatic logic [7:0] expected_rdata(input reg_addr_t addr);
	case (addr)
		REG_LEN:  return 8'hff;
		REG_ENV:  return m_regs.env;
		REG_POLY: return m_regs.poly;
		default:  return 8'hbf | {1'b0, m_regs.len_en, 6'h00};
	endcase
endfunction

task automatic check_rdata(input logic [7:0] got, input logic [7:0] exp);
	chk_cnt++;
	if (got !== exp) begin
		err_cnt++;
		$display("FAILED rdata: got 0x%h, expected 0x%h at %0t", got, exp, $time);
	end
endtask

task automatic check_sample(input logic [3:0] got, input logic [3:0] exp);
	chk_cnt++;
	if (got !== exp) begin
		err_cnt++;
		$display("FAILED sample: got 0x%h, expected 0x%h at %0t", got, exp, $time);
	end
endtask

task automatic check_active(input logic got, input logic exp);
	chk_cnt++;
	if (got !== exp) begin
		err_cnt++;
		$display("FAILED active: got 0x%h, expected 0x%h at %0t", got, exp, $time);
	end
endtask

`endif

// File: dv/noise_tb.sv
`default_nettype none
`timescale 1ns/100ps

module noise_tb
	import apu_bus_pkg::*, noise_pkg::*;
();

	localparam int FRAME_DIV = 64;

	logic         clk;
	logic         arst_n;
	apu_bus_req_t bus;
	logic [7:0]   rdata;
	logic [3:0]   sample;
	logic         active;
	integer       seed;
	int unsigned  tests_run;
	int unsigned  tests_failed;
	int unsigned  base_err; // errors before the running test

	`include "noise_model.svh"

	noise_channel_top #(
		.FRAME_DIV (FRAME_DIV)
	) u_noise_channel_top (
		.clk    (clk),
		.arst_n (arst_n),
		.bus    (bus),
		.rdata  (rdata),
		.sample (sample),
		.active (active)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk or negedge arst_n)
		model_step(!arst_n, bus);

	// registered outputs against the model every cycle
	always @(negedge clk) begin
		if (arst_n) begin
			check_active(active, m_active);
			check_sample(sample, m_sample);
		end
	end

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic bus_write(input reg_addr_t addr, input logic [7:0] data);
		bus.wr    = 1'b1;
		bus.addr  = addr;
		bus.wdata = data;
		@(negedge clk);
		bus.wr = 1'b0;
	endtask

	task automatic read_and_check(input reg_addr_t addr);
		check_rdata(rdata, 8'h00); // read level still low
		bus.rd   = 1'b1;
		bus.addr = addr;
		@(negedge clk);
		check_rdata(rdata, expected_rdata(addr));
		bus.rd = 1'b0;
	endtask

	task automatic wait_active(input logic level, input int limit, output int cycles);
		cycles = 0;
		while (active !== level && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (active !== level) begin
			err_cnt++;
			$display("timeout: active did not reach %0d within %0d cycles", level, limit);
		end
	endtask

	task automatic run_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (err_cnt != base_err)
			tests_failed++;
		$display("test %-9s %s, %0d errors", name,
			(err_cnt == base_err) ? "ok" : "failed", err_cnt - base_err);
		base_err = err_cnt;
	endtask

	initial begin
		logic [7:0] val;
		logic [7:0] p;
		int         cyc;
		int         per;
		seed         = 32'h5922_74d1;
		arst_n       = 1'b0;
		bus          = '0;
		err_cnt      = 0;
		chk_cnt      = 0;
		tests_run    = 0;
		tests_failed = 0;
		base_err     = 0;
		repeat (5) @(negedge clk);
		arst_n = 1'b1;

		for (int n = 0; n < 24; n++) begin
			bus_write(reg_addr_t'(n % 4), rand_byte());
			read_and_check(reg_addr_t'(n % 4));
		end
		end_test("readback");

		val = rand_byte();
		bus_write(REG_ENV, 8'hf0);  // loud, frozen envelope
		bus_write(REG_LEN, val);
		bus_write(REG_CTRL, 8'hc0); // trigger with length on
		wait_active(1'b1, 4, cyc);
		wait_active(1'b0, 65 * FRAME_DIV, cyc);
		bus_write(REG_LEN, val);
		bus_write(REG_CTRL, 8'h80); // same length, counter off
		wait_active(1'b1, 4, per);
		run_cycles(cyc + FRAME_DIV);
		check_active(active, 1'b1);
		end_test("length");

		val = rand_byte();
		if (val[7:3] == 5'd0)
			val[3] = 1'b1;          // keep the DAC on
		per = val[0] ? 2 : 1;
		bus_write(REG_POLY, 8'h00); // fast noise
		bus_write(REG_ENV, {val[7:3], 3'(per)});
		bus_write(REG_CTRL, 8'h80);
		run_cycles(17 * 4 * FRAME_DIV * per); // enough steps to hit a rail
		val = rand_byte() | 8'h10;
		bus_write(REG_ENV, {val[7:4], 4'h0});
		bus_write(REG_CTRL, 8'h80);
		run_cycles(2);
		repeat (8 * FRAME_DIV) begin
			@(negedge clk);
			if (sample != 4'h0)
				check_sample(sample, val[7:4]);
		end
		end_test("envelope");

		for (int w = 0; w < 2; w++) begin
			val = rand_byte();
			p   = rand_byte();
			bus_write(REG_ENV, {val[7:4] | 4'h8, 4'h0});
			bus_write(REG_POLY, {3'b000, p[4], w[0], 1'b0, p[1:0]});
			bus_write(REG_CTRL, 8'h80);
			run_cycles(3000); // long enough for the slowest shift clock
		end
		end_test("lfsr");

		val = rand_byte();
		bus_write(REG_ENV, {5'b00000, val[2:0]}); // nothing to play
		bus_write(REG_CTRL, 8'h80);
		run_cycles(1);
		repeat (2 * FRAME_DIV) begin
			@(negedge clk);
			check_active(active, 1'b0);
			check_sample(sample, 4'h0);
		end
		bus_write(REG_ENV, {val[7:4] | 4'h1, 4'h0});
		bus_write(REG_CTRL, 8'h80);
		wait_active(1'b1, 4, cyc);
		end_test("dac_off");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module noise_tb -f tb.f -o noise_sim

status=0
./obj_dir/noise_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation finished: FAIL" sim.log; then
	echo "run_sim: simulation failed"
	exit 1
fi
echo "run_sim: simulation passed"

// File: source/apu_bus_pkg.sv
`default_nettype none

package apu_bus_pkg;

	// register offsets inside the noise voice window
	typedef enum logic [1:0] {
		REG_LEN  = 2'd0, // length load, write only
		REG_ENV  = 2'd1, // volume envelope
		REG_POLY = 2'd2, // polynomial counter
		REG_CTRL = 2'd3  // trigger and length enable
	} reg_addr_t;

	// one CPU access per cycle, wr is a single-cycle strobe
	typedef struct packed {
		logic      wr;    // write strobe
		logic      rd;    // read level
		reg_addr_t addr;  // register offset
		logic [7:0] wdata; // write data
	} apu_bus_req_t;

endpackage

`default_nettype wire

// File: source/frame_sequencer.sv
`default_nettype none
`timescale 1ns/100ps

module frame_sequencer #(
	parameter int FRAME_DIV = 64 // clocks per 256 Hz step
) (
	input  logic clk,
	input  logic arst_n,
	output logic len_tick,
	output logic env_tick
);

	localparam int CW = $clog2(FRAME_DIV);
	localparam logic [CW-1:0] LAST = CW'(FRAME_DIV - 1);

	logic [CW-1:0] cyc_cnt;
	logic [1:0]    step;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cyc_cnt <= '0;
			step    <= 2'd0;
		end else begin
			cyc_cnt <= len_tick ? '0 : cyc_cnt + 1'b1;
			if (len_tick)
				step <= step + 2'd1; // wraps every four ticks
		end
	end

	assign len_tick = (cyc_cnt == LAST);
	assign env_tick = len_tick && (step == 2'd3); // 64 Hz

	// ticks are single-cycle and the envelope rate rides on the length rate
	tick_shape: assert property (
		@(posedge clk) disable iff (!arst_n)
		(env_tick |-> len_tick) and (len_tick |=> !len_tick)
	) else $error("frame_sequencer: tick spacing broken");

endmodule

`default_nettype wire

// File: source/noise_channel_top.sv
`default_nettype none
`timescale 1ns/100ps

module noise_channel_top
	import apu_bus_pkg::*, noise_pkg::*;
#(
	parameter int FRAME_DIV = 64 // small for simulation
) (
	input  logic         clk,
	input  logic         arst_n,
	input  apu_bus_req_t bus,
	output logic [7:0]   rdata,
	output logic [3:0]   sample,
	output logic         active
);

	noise_regs_t regs;
	logic        trigger;
	logic        len_write;
	logic        len_tick;
	logic        env_tick;
	logic        dac_on;
	logic [3:0]  volume;
	logic        noise_bit;

	// DAC is off when the envelope can only ever produce silence
	assign dac_on = (regs.env.init_vol != 4'h0) || regs.env.env_up;

	noise_regs u_noise_regs (
		.clk       (clk),
		.arst_n    (arst_n),
		.bus       (bus),
		.rdata     (rdata),
		.regs      (regs),
		.trigger   (trigger),
		.len_write (len_write)
	);

	frame_sequencer #(
		.FRAME_DIV (FRAME_DIV)
	) u_frame_sequencer (
		.clk      (clk),
		.arst_n   (arst_n),
		.len_tick (len_tick),
		.env_tick (env_tick)
	);

	noise_length u_noise_length (
		.clk       (clk),
		.arst_n    (arst_n),
		.trigger   (trigger),
		.len_write (len_write),
		.len_tick  (len_tick),
		.len_load  (regs.len_load),
		.len_en    (regs.len_en),
		.dac_on    (dac_on),
		.active    (active)
	);

	noise_envelope u_noise_envelope (
		.clk      (clk),
		.arst_n   (arst_n),
		.trigger  (trigger),
		.env_tick (env_tick),
		.env      (regs.env),
		.volume   (volume)
	);

	noise_lfsr u_noise_lfsr (
		.clk       (clk),
		.arst_n    (arst_n),
		.trigger   (trigger),
		.active    (active),
		.poly      (regs.poly),
		.noise_bit (noise_bit)
	);

	// output sample, low LFSR bit inverted gates the volume
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			sample <= 4'h0;
		else
			sample <= (active && !noise_bit) ? volume : 4'h0;
	end

endmodule

`default_nettype wire

// File: source/noise_envelope.sv
`default_nettype none
`timescale 1ns/100ps

module noise_envelope
	import noise_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       trigger,
	input  logic       env_tick,
	input  env_cfg_t   env,
	output logic [3:0] volume
);

	logic [2:0] per_cnt;
	logic       expire;
	logic [3:0] vol_step;

	// zero counter also counts as expired, covers a period written after trigger
	assign expire = (per_cnt <= 3'd1);

	// one step in the set direction, held at the rails
	always_comb begin
		vol_step = volume;
		if (env.env_up) begin
			if (volume != 4'hf)
				vol_step = volume + 4'd1;
		end else begin
			if (volume != 4'h0)
				vol_step = volume - 4'd1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			volume  <= 4'h0;
			per_cnt <= 3'd0;
		end else if (trigger) begin
			volume  <= env.init_vol;
			per_cnt <= env.env_period;
		end else if (env_tick && env.env_period != 3'd0) begin
			if (expire) begin
				per_cnt <= env.env_period; // reload
				volume  <= vol_step;
			end else begin
				per_cnt <= per_cnt - 3'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/noise_length.sv
`default_nettype none
`timescale 1ns/100ps

module noise_length (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       trigger,
	input  logic       len_write,
	input  logic       len_tick,
	input  logic [5:0] len_load,
	input  logic       len_en,
	input  logic       dac_on,
	output logic       active
);

	logic [6:0] len_cnt; // counts 64 down to 0

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			len_cnt <= 7'd0;
			active  <= 1'b0;
		end else begin
			if (len_write) begin
				len_cnt <= 7'd64 - 7'(len_load);
			end else if (trigger) begin
				if (len_cnt == 7'd0)
					len_cnt <= 7'd64; // full length after expiry
			end else if (len_tick && len_en && len_cnt != 7'd0) begin
				len_cnt <= len_cnt - 7'd1;
			end

			// trigger decides first, expiry only when no trigger this cycle
			if (trigger)
				active <= dac_on;
			else if (len_tick && len_en && len_cnt == 7'd1 && !len_write)
				active <= 1'b0; // counter reaches zero now
		end
	end

	// the voice only comes up through a trigger with the DAC powered
	active_needs_dac: assert property (
		@(posedge clk) disable iff (!arst_n)
		$rose(active) |-> $past(trigger && dac_on)
	) else $error("noise_length: active set without trigger and DAC on");

endmodule

`default_nettype wire

// File: source/noise_lfsr.sv
`default_nettype none
`timescale 1ns/100ps

module noise_lfsr
	import noise_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      trigger,
	input  logic      active,
	input  poly_cfg_t poly,
	output logic      noise_bit
);

	logic [21:0] period;   // divisor << shift, up to 112 << 15
	logic [21:0] div_cnt;
	logic        shift_en;
	logic [14:0] lfsr;
	logic        fb;
	logic [14:0] lfsr_next;

	assign period   = 22'(lfsr_divisor(poly.div_code)) << poly.shift;
	// >= so a smaller period written mid-count does not run the counter around
	assign shift_en = active && (div_cnt >= period - 22'd1);

	assign fb = lfsr[0] ^ lfsr[1];

	always_comb begin
		lfsr_next = {fb, lfsr[14:1]};
		if (poly.width7)
			lfsr_next[6] = fb; // short loop, 127 states
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= '0;
			lfsr    <= '0;
		end else if (trigger) begin
			div_cnt <= '0;           // divider restarts
			lfsr    <= 15'h7fff;
		end else if (active) begin
			if (shift_en) begin
				div_cnt <= '0;
				lfsr    <= lfsr_next;
			end else begin
				div_cnt <= div_cnt + 22'd1;
			end
		end
	end

	assign noise_bit = lfsr[0];

endmodule

`default_nettype wire

// File: source/noise_pkg.sv
`default_nettype none

package noise_pkg;

	// envelope register, same bit order as the CPU byte
	typedef struct packed {
		logic [3:0] init_vol;   // bits 7:4
		logic       env_up;     // bit 3, 1 = louder
		logic [2:0] env_period; // bits 2:0, 0 freezes
	} env_cfg_t;

	// polynomial register
	typedef struct packed {
		logic [3:0] shift;    // bits 7:4, clock shift
		logic       width7;   // bit 3, short LFSR mode
		logic [2:0] div_code; // bits 2:0, divisor select
	} poly_cfg_t;

	// register image seen by the voice blocks
	typedef struct packed {
		logic [5:0] len_load; // written length
		env_cfg_t   env;
		poly_cfg_t  poly;
		logic       len_en;   // length counter enable
	} noise_regs_t;

	// base divisor before the shift, code 0 is the odd one out
	function automatic logic [6:0] lfsr_divisor(input logic [2:0] div_code);
		logic [6:0] base;
		base = (div_code == 3'd0) ? 7'd8 : {div_code, 4'b0000};
		return base;
	endfunction

endpackage

`default_nettype wire

// File: source/noise_regs.sv
`default_nettype none
`timescale 1ns/100ps

module noise_regs
	import apu_bus_pkg::*, noise_pkg::*;
(
	input  logic         clk,
	input  logic         arst_n,
	input  apu_bus_req_t bus,
	output logic [7:0]   rdata,
	output noise_regs_t  regs,
	output logic         trigger,
	output logic         len_write
);

	// register writes land on the edge after the strobe, pulses follow for one cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			regs      <= '0;
			trigger   <= 1'b0;
			len_write <= 1'b0;
		end else begin
			trigger   <= 1'b0; // pulses default low
			len_write <= 1'b0;
			if (bus.wr) begin
				unique case (bus.addr)
					REG_LEN: begin
						regs.len_load <= bus.wdata[5:0]; // top two bits unused
						len_write     <= 1'b1;
					end
					REG_ENV: begin
						regs.env <= env_cfg_t'(bus.wdata);
					end
					REG_POLY: begin
						regs.poly <= poly_cfg_t'(bus.wdata);
					end
					REG_CTRL: begin
						regs.len_en <= bus.wdata[6];
						trigger     <= bus.wdata[7]; // not stored, fires once
					end
				endcase
			end
		end
	end

	// read-back, unreadable bits come back as ones
	always_comb begin
		rdata = 8'h00;
		if (bus.rd) begin
			unique case (bus.addr)
				REG_LEN:  rdata = 8'hff;                     // length is write only
				REG_ENV:  rdata = regs.env;
				REG_POLY: rdata = regs.poly;
				REG_CTRL: rdata = {1'b1, regs.len_en, 6'h3f}; // only bit 6 visible
			endcase
		end
	end

	// the bus is a single master, a cycle is either a read or a write
	wr_rd_exclusive: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(bus.wr && bus.rd)
	) else $error("noise_regs: wr and rd high in the same cycle");

endmodule

`default_nettype wire

// File: tb.f
+incdir+dv
source/apu_bus_pkg.sv
source/noise_pkg.sv
source/noise_regs.sv
source/frame_sequencer.sv
source/noise_length.sv
source/noise_envelope.sv
source/noise_lfsr.sv
source/noise_channel_top.sv
dv/noise_tb.sv
